/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP = tb_qu_queue_unit
FILELIST = sources.f
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Testbench passed" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/qu_fifo.sv */
`include "qu_settings.svh"

module qu_fifo #(
	parameter int DATA_WID = `QU_DATA_WID,
	parameter int DEPTH = `QU_DEPTH
)
(
	input logic clk,
	input logic rst,
	input logic clr_i,
	input logic push_i,
	input logic pop_i,
	input logic [DATA_WID-1:0] wdata_i,
	output logic [DATA_WID-1:0] rdata_o,
	output qu_pkg::qu_cnt_t cnt_o,
	output logic empty_o,
	output logic full_o
);

	localparam int PTR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [DATA_WID-1:0] mem [DEPTH];
	logic [PTR_WID-1:0] wr_ptr;
	logic [PTR_WID-1:0] rd_ptr;
	qu_pkg::qu_cnt_t cnt_nxt;

	always_comb
	begin
		case ({push_i, pop_i})
		2'b10:	cnt_nxt = cnt_o + 1'b1;
		2'b01:	cnt_nxt = cnt_o - 1'b1;
		default:	cnt_nxt = cnt_o;
		endcase
	end

	// clear wins over push and pop.
	always_ff @(posedge clk)
	begin
		if (rst || clr_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt_o <= '0;
			empty_o <= 1'b1;
			full_o <= 1'b0;
		end
		else
		begin
			if (push_i)
				wr_ptr <= (wr_ptr == PTR_WID'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			if (pop_i)
				rd_ptr <= (rd_ptr == PTR_WID'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			cnt_o <= cnt_nxt;
			empty_o <= (cnt_nxt == '0);
			full_o <= (cnt_nxt == qu_pkg::qu_cnt_t'(DEPTH));
		end
	end

	always_ff @(posedge clk)
	begin
		if (push_i)
			mem[wr_ptr] <= wdata_i;
	end

	assign rdata_o = mem[rd_ptr];

	// the bank gates strobes with the flags.
	a_no_push_full: assert property (@(posedge clk) disable iff (rst) push_i |-> !full_o);
	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop_i |-> !empty_o);

endmodule

/* hw/qu_pkg.sv */
`include "qu_settings.svh"

package qu_pkg;

	// queue word, also the write-back result.
	typedef logic [`QU_DATA_WID-1:0] qu_data_t;
	typedef logic [$clog2(`QU_NQUEUES)-1:0] qu_sel_t;
	typedef logic [1:0] qu_func_t;

	// reorder-buffer tag and its stomp mask.
	typedef logic [`QU_TAG_WID-1:0] qu_tag_t;
	typedef logic [(1 << `QU_TAG_WID)-1:0] qu_mask_t;

	// one bit per queue.
	typedef logic [`QU_NQUEUES-1:0] qu_strobe_t;

	// holds 0 to QU_DEPTH.
	typedef logic [`QU_CNT_WID-1:0] qu_cnt_t;
	typedef logic [`QU_DATA_WID/8-1:0] qu_we_t;

endpackage

/* hw/qu_queue_bank.sv */
`include "qu_settings.svh"

module qu_queue_bank
(
	input logic clk,
	input logic rst,
	input qu_pkg::qu_strobe_t q_rst_i,
	input qu_pkg::qu_strobe_t q_wr_i,
	input qu_pkg::qu_strobe_t q_rd_i,
	input qu_pkg::qu_strobe_t q_stat_i,
	input qu_pkg::qu_data_t q_wr_data_i,
	output qu_pkg::qu_data_t q_rd_data_o,
	output qu_pkg::qu_cnt_t q_cnt_o,
	output logic q_empty_o,
	output logic q_full_o
);

	qu_pkg::qu_data_t rdata [`QU_NQUEUES];
	qu_pkg::qu_cnt_t cnt [`QU_NQUEUES];
	qu_pkg::qu_strobe_t empty;
	qu_pkg::qu_strobe_t full;
	qu_pkg::qu_strobe_t push;
	qu_pkg::qu_strobe_t pop;
	qu_pkg::qu_strobe_t any_stb;
	qu_pkg::qu_sel_t sel;

	// rejected writes and reads leave the queue alone.
	assign push = q_wr_i & ~full;
	assign pop = q_rd_i & ~empty;
	assign any_stb = q_rst_i | q_wr_i | q_rd_i | q_stat_i;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// queues. 14 is the NaN trace queue.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	for (genvar gi = 0; gi < `QU_NQUEUES; gi++)
	begin : g_queue
		qu_fifo i_fifo
		(
			.clk(clk),
			.rst(rst),
			.clr_i(q_rst_i[gi]),
			.push_i(push[gi]),
			.pop_i(pop[gi]),
			.wdata_i(q_wr_data_i),
			.rdata_o(rdata[gi]),
			.cnt_o(cnt[gi]),
			.empty_o(empty[gi]),
			.full_o(full[gi])
		);
	end

	always_comb
	begin
		sel = '0;
		for (int i = 0; i < `QU_NQUEUES; i++)
			if (any_stb[i])
				sel = qu_pkg::qu_sel_t'(i);
	end

	// status as seen before the queue acts.
	always_ff @(posedge clk)
	begin
		if (|any_stb)
		begin
			q_rd_data_o <= rdata[sel];
			q_cnt_o <= cnt[sel];
			q_empty_o <= empty[sel];
			q_full_o <= full[sel];
		end
	end

	a_one_strobe: assert property (@(posedge clk) disable iff (rst)
		$onehot0({q_rst_i, q_wr_i, q_rd_i, q_stat_i}));

endmodule

/* hw/qu_queue_manager.sv */
`include "qu_settings.svh"

module qu_queue_manager
(
	input logic clk,
	input logic rst,
	input logic issue_valid_i,
	input qu_pkg::qu_func_t func_i,
	input qu_pkg::qu_sel_t qsel_i,
	input qu_pkg::qu_data_t wdata_i,
	input qu_pkg::qu_tag_t tag_i,
	input qu_pkg::qu_mask_t stomp_i,
	output qu_pkg::qu_strobe_t q_rst_o,
	output qu_pkg::qu_strobe_t q_wr_o,
	output qu_pkg::qu_strobe_t q_rd_o,
	output qu_pkg::qu_strobe_t q_stat_o,
	output qu_pkg::qu_data_t q_wr_data_o,
	input qu_pkg::qu_data_t q_rd_data_i,
	input qu_pkg::qu_cnt_t q_cnt_i,
	input logic q_empty_i,
	input logic q_full_i,
	output logic done_o,
	output qu_pkg::qu_tag_t done_tag_o,
	output qu_pkg::qu_data_t result_o,
	output qu_pkg::qu_we_t result_we_o,
	output logic exc_o
);

	qu_pkg::qu_strobe_t sel_oh;
	logic issue_ok;
	logic s1_valid;
	logic s2_valid;
	logic wb_ok;
	qu_pkg::qu_tag_t s1_tag;
	qu_pkg::qu_tag_t s2_tag;
	qu_pkg::qu_func_t s1_func;
	qu_pkg::qu_func_t s2_func;
	qu_pkg::qu_data_t res_nxt;
	qu_pkg::qu_we_t we_nxt;
	logic exc_nxt;

	assign sel_oh = qu_pkg::qu_strobe_t'(1) << qsel_i;
	assign issue_ok = issue_valid_i && !stomp_i[tag_i];
	assign wb_ok = s2_valid && !stomp_i[s2_tag];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decode to queue strobes.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			q_rst_o <= '0;
			q_wr_o <= '0;
			q_rd_o <= '0;
			q_stat_o <= '0;
		end
		else
		begin
			q_rst_o <= '0;
			q_wr_o <= '0;
			q_rd_o <= '0;
			q_stat_o <= '0;
			if (issue_ok)
				case (func_i)
				`QU_FN_RESETQ:	q_rst_o <= sel_oh;
				`QU_FN_WRITEQ:	q_wr_o <= sel_oh;
				`QU_FN_READQ:	q_rd_o <= sel_oh;
				default:	q_stat_o <= sel_oh;
				endcase
		end
	end

	always_ff @(posedge clk)
	begin
		q_wr_data_o <= wdata_i;
	end

	// in-flight stages, stomp drops the valid bit.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end
		else
		begin
			s1_valid <= issue_ok;
			s2_valid <= s1_valid && !stomp_i[s1_tag];
		end
	end

	always_ff @(posedge clk)
	begin
		s1_tag <= tag_i;
		s1_func <= func_i;
		s2_tag <= s1_tag;
		s2_func <= s1_func;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write-back.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb
	begin
		res_nxt = '0;
		we_nxt = '0;
		exc_nxt = 1'b0;
		case (s2_func)
		`QU_FN_READQ:
			if (q_empty_i)
				exc_nxt = 1'b1;
			else
			begin
				res_nxt = q_rd_data_i;
				we_nxt = '1;
			end
		`QU_FN_WRITEQ:
			exc_nxt = q_full_i;
		`QU_FN_STATQ:
			begin
				res_nxt[`QU_CNT_WID-1:0] = q_cnt_i;
				res_nxt[8] = q_empty_i;
				res_nxt[9] = q_full_i;
				we_nxt = '1;
			end
		default:	;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			done_o <= 1'b0;
			result_we_o <= '0;
			exc_o <= 1'b0;
		end
		else
		begin
			done_o <= wb_ok;
			result_we_o <= wb_ok ? we_nxt : '0;
			exc_o <= wb_ok && exc_nxt;
		end
	end

	always_ff @(posedge clk)
	begin
		done_tag_o <= s2_tag;
		result_o <= res_nxt;
	end

	// nothing can complete before a full trip through the pipe.
	a_quiet_after_rst: assert property (@(posedge clk)
		$fell(rst) |-> !done_o [*`QU_LATENCY]);

endmodule

/* hw/qu_queue_unit.sv */
module qu_queue_unit
(
	input logic clk,
	input logic rst,
	input logic issue_valid_i,
	input qu_pkg::qu_func_t func_i,
	input qu_pkg::qu_sel_t qsel_i,
	input qu_pkg::qu_data_t wdata_i,
	input qu_pkg::qu_tag_t tag_i,
	input qu_pkg::qu_mask_t stomp_i,
	output logic done_o,
	output qu_pkg::qu_tag_t done_tag_o,
	output qu_pkg::qu_data_t result_o,
	output qu_pkg::qu_we_t result_we_o,
	output logic exc_o
);

	qu_pkg::qu_strobe_t q_rst;
	qu_pkg::qu_strobe_t q_wr;
	qu_pkg::qu_strobe_t q_rd;
	qu_pkg::qu_strobe_t q_stat;
	qu_pkg::qu_data_t q_wr_data;
	qu_pkg::qu_data_t q_rd_data;
	qu_pkg::qu_cnt_t q_cnt;
	logic q_empty;
	logic q_full;

	qu_queue_manager i_qu_queue_manager
	(
		.clk(clk),
		.rst(rst),
		.issue_valid_i(issue_valid_i),
		.func_i(func_i),
		.qsel_i(qsel_i),
		.wdata_i(wdata_i),
		.tag_i(tag_i),
		.stomp_i(stomp_i),
		.q_rst_o(q_rst),
		.q_wr_o(q_wr),
		.q_rd_o(q_rd),
		.q_stat_o(q_stat),
		.q_wr_data_o(q_wr_data),
		.q_rd_data_i(q_rd_data),
		.q_cnt_i(q_cnt),
		.q_empty_i(q_empty),
		.q_full_i(q_full),
		.done_o(done_o),
		.done_tag_o(done_tag_o),
		.result_o(result_o),
		.result_we_o(result_we_o),
		.exc_o(exc_o)
	);

	qu_queue_bank i_qu_queue_bank
	(
		.clk(clk),
		.rst(rst),
		.q_rst_i(q_rst),
		.q_wr_i(q_wr),
		.q_rd_i(q_rd),
		.q_stat_i(q_stat),
		.q_wr_data_i(q_wr_data),
		.q_rd_data_o(q_rd_data),
		.q_cnt_o(q_cnt),
		.q_empty_o(q_empty),
		.q_full_o(q_full)
	);

endmodule

/* hw/qu_settings.svh */
`ifndef QU_SETTINGS_SVH
`define QU_SETTINGS_SVH

// queue bank geometry.
`define QU_NQUEUES	16
`define QU_DATA_WID	64
`define QU_DEPTH	8
`define QU_CNT_WID	4

// issue side.
`define QU_TAG_WID	3
`define QU_LATENCY	3

// function codes.
`define QU_FN_RESETQ	2'd0
`define QU_FN_WRITEQ	2'd1
`define QU_FN_READQ	2'd2
`define QU_FN_STATQ	2'd3

`endif

/* sim/tb_qu_queue_unit.sv */
`include "qu_settings.svh"

module tb_qu_queue_unit;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_RAND = 600;
	localparam int N_DIRECTED = 80;
	localparam int WATCHDOG_NS = 2 * (N_DIRECTED + N_RAND) * 20;

	logic clk;
	logic rst;
	logic issue_valid_i;
	qu_pkg::qu_func_t func_i;
	qu_pkg::qu_sel_t qsel_i;
	qu_pkg::qu_data_t wdata_i;
	qu_pkg::qu_tag_t tag_i;
	qu_pkg::qu_mask_t stomp_i;
	logic done_o;
	qu_pkg::qu_tag_t done_tag_o;
	qu_pkg::qu_data_t result_o;
	qu_pkg::qu_we_t result_we_o;
	logic exc_o;

	// model queues and the three-deep delay line.
	qu_pkg::qu_data_t mq [`QU_NQUEUES][$];
	logic p_valid [3];
	qu_pkg::qu_tag_t p_tag [3];
	qu_pkg::qu_data_t p_data [3];
	qu_pkg::qu_we_t p_we [3];
	logic p_exc [3];
	string p_name [3];
	string test_name;
	qu_pkg::qu_tag_t next_tag;
	qu_pkg::qu_tag_t last_tag;
	int value_errors;
	int protocol_errors;
	int done_count;

	qu_queue_unit i_qu_queue_unit
	(
		.clk(clk),
		.rst(rst),
		.issue_valid_i(issue_valid_i),
		.func_i(func_i),
		.qsel_i(qsel_i),
		.wdata_i(wdata_i),
		.tag_i(tag_i),
		.stomp_i(stomp_i),
		.done_o(done_o),
		.done_tag_o(done_tag_o),
		.result_o(result_o),
		.result_we_o(result_we_o),
		.exc_o(exc_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// compare tasks.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic check_data(input string what, input qu_pkg::qu_data_t exp,
		input qu_pkg::qu_data_t act);
		if (act !== exp)
		begin
			value_errors++;
			$display("Error %s result: expected %h, actual %h", what, exp, act);
		end
	endtask

	task automatic check_tag(input string what, input qu_pkg::qu_tag_t exp,
		input qu_pkg::qu_tag_t act);
		if (act !== exp)
		begin
			value_errors++;
			$display("Error %s tag: expected %0d, actual %0d", what, exp, act);
		end
	endtask

	task automatic check_we(input string what, input qu_pkg::qu_we_t exp,
		input qu_pkg::qu_we_t act);
		if (act !== exp)
		begin
			value_errors++;
			$display("Error %s byte enables: expected %h, actual %h", what, exp, act);
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		if (act !== exp)
		begin
			value_errors++;
			$display("Error %s exception: expected %b, actual %b", what, exp, act);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic apply_to_model(input qu_pkg::qu_func_t fn, input qu_pkg::qu_sel_t qs,
		input qu_pkg::qu_data_t wd);
		int n;
		n = mq[qs].size();
		p_data[0] = '0;
		p_we[0] = '0;
		p_exc[0] = 1'b0;
		case (fn)
		`QU_FN_RESETQ:
			mq[qs].delete();
		`QU_FN_WRITEQ:
			if (n == `QU_DEPTH)
				p_exc[0] = 1'b1;
			else
				mq[qs].push_back(wd);
		`QU_FN_READQ:
			if (n == 0)
				p_exc[0] = 1'b1;
			else
			begin
				p_data[0] = mq[qs].pop_front();
				p_we[0] = '1;
			end
		default:
			begin
				p_data[0][`QU_CNT_WID-1:0] = qu_pkg::qu_cnt_t'(n);
				p_data[0][8] = (n == 0);
				p_data[0][9] = (n == `QU_DEPTH);
				p_we[0] = '1;
			end
		endcase
	endtask

	task automatic compare_done();
		if (p_valid[2])
		begin
			if (done_o !== 1'b1)
			begin
				protocol_errors++;
				$display("%s: no done for tag %0d three cycles after issue", p_name[2],
					p_tag[2]);
			end
			else
			begin
				done_count++;
				check_tag(p_name[2], p_tag[2], done_tag_o);
				check_data(p_name[2], p_data[2], result_o);
				check_we(p_name[2], p_we[2], result_we_o);
				check_flag(p_name[2], p_exc[2], exc_o);
			end
		end
		else if (done_o !== 1'b0)
		begin
			protocol_errors++;
			$display("done pulse at %0d ns has no matching issue", $time);
		end
	endtask

	// outputs and issue inputs are both stable at the falling edge.
	always @(negedge clk)
	begin
		if (rst !== 1'b0)
		begin
			for (int i = 0; i < 3; i++)
				p_valid[i] = 1'b0;
		end
		else
		begin
			compare_done();
			for (int i = 2; i > 0; i--)
			begin
				p_valid[i] = p_valid[i-1] && !stomp_i[p_tag[i-1]];
				p_tag[i] = p_tag[i-1];
				p_data[i] = p_data[i-1];
				p_we[i] = p_we[i-1];
				p_exc[i] = p_exc[i-1];
				p_name[i] = p_name[i-1];
			end
			p_valid[0] = issue_valid_i && !stomp_i[tag_i];
			p_tag[0] = tag_i;
			p_name[0] = test_name;
			if (p_valid[0])
				apply_to_model(func_i, qsel_i, wdata_i);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic qu_pkg::qu_data_t rand_word();
		return {$urandom, $urandom};
	endfunction

	task automatic drive_cycle(input logic valid, input qu_pkg::qu_func_t fn,
		input qu_pkg::qu_sel_t qs, input qu_pkg::qu_data_t wd, input qu_pkg::qu_mask_t stomp);
		@(posedge clk);
		issue_valid_i <= valid;
		func_i <= fn;
		qsel_i <= qs;
		wdata_i <= wd;
		tag_i <= next_tag;
		stomp_i <= stomp;
		if (valid)
		begin
			last_tag = next_tag;
			next_tag = next_tag + 1'b1;
		end
	endtask

	task automatic issue_instr(input qu_pkg::qu_func_t fn, input qu_pkg::qu_sel_t qs,
		input qu_pkg::qu_mask_t stomp);
		drive_cycle(1'b1, fn, qs, rand_word(), stomp);
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
			drive_cycle(1'b0, '0, '0, '0, '0);
	endtask

	// writes dominate for 64 cycles, then reads.
	task automatic random_cycle(input int cyc);
		int pick;
		int wr_pct;
		qu_pkg::qu_func_t fn;
		qu_pkg::qu_sel_t qs;
		qu_pkg::qu_mask_t stomp;
		wr_pct = ((cyc / 64) % 2 == 0) ? 60 : 25;
		pick = int'($urandom_range(99, 0));
		if (pick < wr_pct)
			fn = `QU_FN_WRITEQ;
		else if (pick < 85)
			fn = `QU_FN_READQ;
		else if (pick < 96)
			fn = `QU_FN_STATQ;
		else
			fn = `QU_FN_RESETQ;
		if ($urandom_range(1, 0) == 0)
			qs = qu_pkg::qu_sel_t'($urandom_range(15, 12));
		else
			qs = qu_pkg::qu_sel_t'($urandom_range(15, 0));
		stomp = '0;
		if ($urandom_range(15, 0) == 0)
			stomp = qu_pkg::qu_mask_t'(1) << $urandom_range(7, 0);
		drive_cycle($urandom_range(7, 0) != 0, fn, qs, rand_word(), stomp);
	endtask

	initial
	begin
		rst = 1'b1;
		issue_valid_i = 1'b0;
		func_i = '0;
		qsel_i = '0;
		wdata_i = '0;
		tag_i = '0;
		stomp_i = '0;
		next_tag = '0;
		last_tag = '0;
		value_errors = 0;
		protocol_errors = 0;
		done_count = 0;
		test_name = "reset";
		void'($urandom(32'h5f53_b3a8));
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		test_name = "fifo_order";
		for (int i = 0; i < 5; i++)
			issue_instr(`QU_FN_WRITEQ, 4'd3, '0);
		for (int i = 0; i < 5; i++)
			issue_instr(`QU_FN_READQ, 4'd3, '0);
		idle_cycles(4);

		// ninth write is dropped, ninth read finds the queue empty.
		test_name = "empty_full";
		issue_instr(`QU_FN_READQ, 4'd5, '0);
		for (int i = 0; i < 9; i++)
			issue_instr(`QU_FN_WRITEQ, 4'd5, '0);
		for (int i = 0; i < 9; i++)
			issue_instr(`QU_FN_READQ, 4'd5, '0);
		idle_cycles(4);

		test_name = "reset_stat";
		for (int i = 0; i < 4; i++)
			issue_instr(`QU_FN_WRITEQ, 4'd7, '0);
		issue_instr(`QU_FN_STATQ, 4'd7, '0);
		issue_instr(`QU_FN_RESETQ, 4'd7, '0);
		issue_instr(`QU_FN_STATQ, 4'd7, '0);
		idle_cycles(4);

		test_name = "stomp";
		issue_instr(`QU_FN_WRITEQ, 4'd9, '0);
		issue_instr(`QU_FN_WRITEQ, 4'd9, '0);
		issue_instr(`QU_FN_READQ, 4'd9, qu_pkg::qu_mask_t'(1) << next_tag);
		issue_instr(`QU_FN_READQ, 4'd9, '0);
		// the read above is hit one cycle later and still pops.
		issue_instr(`QU_FN_STATQ, 4'd9, qu_pkg::qu_mask_t'(1) << last_tag);
		issue_instr(`QU_FN_READQ, 4'd9, '0);
		issue_instr(`QU_FN_STATQ, 4'd9, '0);
		idle_cycles(4);

		test_name = "random";
		for (int c = 0; c < N_RAND; c++)
			random_cycle(c);
		idle_cycles(6);

		$display("done pulses %0d, value errors %0d, protocol errors %0d", done_count,
			value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0 && done_count > 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Testbench failed");
		$finish;
	end

endmodule

/* sources.f */
+incdir+hw
hw/qu_pkg.sv
hw/qu_fifo.sv
hw/qu_queue_bank.sv
hw/qu_queue_manager.sv
hw/qu_queue_unit.sv
sim/tb_qu_queue_unit.sv
